// File: zy_net_consts.svh
`ifndef ZY_NET_CONSTS_SVH
`define ZY_NET_CONSTS_SVH

// word format and frame geometry
`define ZN_WORD_SIZE      16
`define ZN_FRAC_BITS      12
`define ZN_INPUT_LEN      19
`define ZN_KERNEL_HEIGHT  4
`define ZN_CONV_LEN       16
`define ZN_CONV_LEN_LOG2  4
`define ZN_NUM_KERNELS    2
`define ZN_OUTPUT_SIZE    4
`define ZN_FIFO_DEPTH     4

// kernel 0 is a plain moving sum at 0.25 per tap
`define ZN_K0_W0  16'h0400
`define ZN_K0_W1  16'h0400
`define ZN_K0_W2  16'h0400
`define ZN_K0_W3  16'h0400

// kernel 1 alternates +0.5 / -0.5
`define ZN_K1_W0  16'h0800
`define ZN_K1_W1  16'hF800
`define ZN_K1_W2  16'h0800
`define ZN_K1_W3  16'hF800

// dense weights, output o and feature k
`define ZN_FC_W_0_0  16'h1000
`define ZN_FC_W_0_1  16'h0000
`define ZN_FC_W_1_0  16'h0000
`define ZN_FC_W_1_1  16'h1000
`define ZN_FC_W_2_0  16'h0800
`define ZN_FC_W_2_1  16'h0800
`define ZN_FC_W_3_0  16'h1000
`define ZN_FC_W_3_1  16'hF000

`define ZN_FC_B_0  16'h0000
`define ZN_FC_B_1  16'h0000
`define ZN_FC_B_2  16'h0100
`define ZN_FC_B_3  16'hFF00

`endif

// File: zy_net_pkg.sv
`default_nettype none

`include "zy_net_consts.svh"

package zy_net_pkg;

    // Q4.12 word and a wide accumulator for full-precision sums
    typedef logic signed [`ZN_WORD_SIZE-1:0] word_t;
    typedef logic signed [39:0]              acc_t;

    typedef word_t [`ZN_NUM_KERNELS-1:0] feat_vec_t;
    typedef word_t [`ZN_OUTPUT_SIZE-1:0] score_vec_t;

    typedef enum logic {
        GAP_ACCUM,
        GAP_HOLD
    } gap_state_t;

    typedef enum logic {
        FC_READ,
        FC_DONE
    } fc_state_t;

    // clamp an already shifted sum into the word range
    function automatic word_t sat_word(input acc_t value);
        acc_t max_v;
        acc_t min_v;
        max_v = (acc_t'(1) <<< (`ZN_WORD_SIZE - 1)) - acc_t'(1);
        min_v = -(acc_t'(1) <<< (`ZN_WORD_SIZE - 1));
        if (value > max_v) begin
            return max_v[`ZN_WORD_SIZE-1:0];
        end else if (value < min_v) begin
            return min_v[`ZN_WORD_SIZE-1:0];
        end
        return value[`ZN_WORD_SIZE-1:0];
    endfunction

endpackage

`default_nettype wire

// File: conv_layer.sv
`default_nettype none

`include "zy_net_consts.svh"

module conv_layer (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              start_i,
    input  logic              kernel_sel_i,
    input  logic              valid_i,
    input  logic              shared_ready_i,
    input  zy_net_pkg::word_t data_i,
    output logic              ready_o,
    output logic              valid_o,
    input  logic              yumi_i,
    output zy_net_pkg::word_t data_o
);

    localparam int FILL_W = $clog2(`ZN_KERNEL_HEIGHT);

    localparam zy_net_pkg::word_t KERNEL_0 [`ZN_KERNEL_HEIGHT] =
        '{`ZN_K0_W0, `ZN_K0_W1, `ZN_K0_W2, `ZN_K0_W3};
    localparam zy_net_pkg::word_t KERNEL_1 [`ZN_KERNEL_HEIGHT] =
        '{`ZN_K1_W0, `ZN_K1_W1, `ZN_K1_W2, `ZN_K1_W3};

    zy_net_pkg::word_t taps       [`ZN_KERNEL_HEIGHT];
    zy_net_pkg::word_t window_q   [`ZN_KERNEL_HEIGHT];
    zy_net_pkg::word_t window_nxt [`ZN_KERNEL_HEIGHT];
    zy_net_pkg::acc_t  dot;
    logic [FILL_W-1:0] fill_q;
    logic              accept;
    logic              window_full;

    // a held result blocks new samples unless it leaves this cycle
    assign ready_o     = ~valid_o | yumi_i;
    assign accept      = valid_i & shared_ready_i;
    assign window_full = (fill_q == FILL_W'(`ZN_KERNEL_HEIGHT - 1));

    always_comb begin
        for (int t = 0; t < `ZN_KERNEL_HEIGHT; t++) begin
            taps[t] = kernel_sel_i ? KERNEL_1[t] : KERNEL_0[t];
        end
        // oldest sample sits at index 0
        for (int t = 0; t < `ZN_KERNEL_HEIGHT - 1; t++) begin
            window_nxt[t] = window_q[t+1];
        end
        window_nxt[`ZN_KERNEL_HEIGHT-1] = data_i;
    end

    always_comb begin
        dot = '0;
        for (int t = 0; t < `ZN_KERNEL_HEIGHT; t++) begin
            dot = dot + zy_net_pkg::acc_t'(taps[t]) * zy_net_pkg::acc_t'(window_nxt[t]);
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fill_q  <= '0;
            valid_o <= 1'b0;
        end else begin
            if (start_i) begin
                fill_q <= '0;
            end else if (accept && !window_full) begin
                fill_q <= fill_q + 1'b1;
            end
            if (accept && window_full) begin
                valid_o <= 1'b1;
            end else if (yumi_i) begin
                valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            for (int t = 0; t < `ZN_KERNEL_HEIGHT; t++) begin
                window_q[t] <= '0;
            end
        end else if (accept) begin
            window_q <= window_nxt;
        end
        if (accept && window_full) begin
            data_o <= zy_net_pkg::sat_word(dot >>> `ZN_FRAC_BITS);
        end
    end

    a_hold_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        valid_o && !yumi_i |=> valid_o && $stable(data_o));

endmodule

`default_nettype wire

// File: gap_layer.sv
`default_nettype none

`include "zy_net_consts.svh"

module gap_layer (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              start_i,
    input  logic              valid_i,
    output logic              ready_o,
    input  zy_net_pkg::word_t data_i,
    output logic              valid_o,
    input  logic              ready_i,
    output zy_net_pkg::word_t data_o
);

    zy_net_pkg::gap_state_t             state_q;
    zy_net_pkg::acc_t                   acc_q;
    zy_net_pkg::acc_t                   acc_next;
    zy_net_pkg::word_t                  abs_val;
    logic [`ZN_CONV_LEN_LOG2-1:0]       cnt_q;
    logic                               accept;
    logic                               last;

    assign ready_o = (state_q == zy_net_pkg::GAP_ACCUM);
    assign valid_o = (state_q == zy_net_pkg::GAP_HOLD);
    assign accept  = valid_i & ready_o;
    assign last    = (cnt_q == `ZN_CONV_LEN_LOG2'(`ZN_CONV_LEN - 1));

    // |-8.0| does not fit, clamp it
    assign abs_val  = zy_net_pkg::sat_word(data_i[`ZN_WORD_SIZE-1] ?
                                           -zy_net_pkg::acc_t'(data_i) :
                                           zy_net_pkg::acc_t'(data_i));
    assign acc_next = acc_q + zy_net_pkg::acc_t'(abs_val);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= zy_net_pkg::GAP_ACCUM;
            acc_q   <= '0;
            cnt_q   <= '0;
        end else if (start_i) begin
            state_q <= zy_net_pkg::GAP_ACCUM;
            acc_q   <= '0;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                zy_net_pkg::GAP_ACCUM: begin
                    if (accept) begin
                        // counter wraps back to zero on the last value
                        cnt_q <= cnt_q + 1'b1;
                        if (last) begin
                            acc_q   <= '0;
                            state_q <= zy_net_pkg::GAP_HOLD;
                        end else begin
                            acc_q <= acc_next;
                        end
                    end
                end
                zy_net_pkg::GAP_HOLD: begin
                    if (ready_i) begin
                        state_q <= zy_net_pkg::GAP_ACCUM;
                    end
                end
                default: state_q <= zy_net_pkg::GAP_ACCUM;
            endcase
        end
    end

    // average is a plain shift since the length is a power of two
    always_ff @(posedge clk_i) begin
        if (accept && last) begin
            data_o <= zy_net_pkg::sat_word(acc_next >>> `ZN_CONV_LEN_LOG2);
        end
    end

endmodule

`default_nettype wire

// File: fc_output_layer.sv
`default_nettype none

`include "zy_net_consts.svh"

module fc_output_layer (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  valid_i,
    output logic                  ready_o,
    input  zy_net_pkg::feat_vec_t data_i,
    output logic                  wen_o,
    input  logic                  full_i,
    output zy_net_pkg::word_t     data_o
);

    localparam int IDX_W = (`ZN_NUM_KERNELS > 1) ? $clog2(`ZN_NUM_KERNELS) : 1;

    zy_net_pkg::feat_vec_t vec_q;
    logic [IDX_W-1:0]      idx_q;
    logic                  busy_q;
    logic                  last;

    assign ready_o = ~busy_q;
    assign wen_o   = busy_q & ~full_i;
    assign data_o  = vec_q[idx_q];
    assign last    = (idx_q == IDX_W'(`ZN_NUM_KERNELS - 1));

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= 1'b0;
            idx_q  <= '0;
        end else if (!busy_q) begin
            if (valid_i) begin
                busy_q <= 1'b1;
                idx_q  <= '0;
            end
        end else if (wen_o) begin
            // kernel 0 goes out first
            if (last) begin
                busy_q <= 1'b0;
                idx_q  <= '0;
            end else begin
                idx_q <= idx_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            vec_q <= data_i;
        end
    end

endmodule

`default_nettype wire

// File: sample_fifo.sv
`default_nettype none

`include "zy_net_consts.svh"

module sample_fifo (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              wen_i,
    output logic              full_o,
    input  zy_net_pkg::word_t data_i,
    input  logic              ren_i,
    output logic              empty_o,
    output zy_net_pkg::word_t data_o
);

    localparam int PTR_W = $clog2(`ZN_FIFO_DEPTH);

    zy_net_pkg::word_t mem [`ZN_FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [PTR_W:0]    count_q;
    logic              do_write;
    logic              do_read;

    assign full_o   = (count_q == (PTR_W+1)'(`ZN_FIFO_DEPTH));
    assign empty_o  = (count_q == '0);
    assign do_write = wen_i & ~full_o;
    assign do_read  = ren_i & ~empty_o;

    // first word falls through
    assign data_o = mem[rd_ptr_q];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_read) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_write) begin
            mem[wr_ptr_q] <= data_i;
        end
    end

    a_no_overflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        full_o |-> !wen_i);

    a_no_underflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        empty_o |-> !ren_i);

endmodule

`default_nettype wire

// File: fc_layer.sv
`default_nettype none

`include "zy_net_consts.svh"

module fc_layer (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   start_i,
    input  zy_net_pkg::word_t      data_i,
    input  logic                   empty_i,
    output logic                   ren_o,
    output logic                   valid_o,
    input  logic                   yumi_i,
    output zy_net_pkg::score_vec_t data_o
);

    localparam int IDX_W = (`ZN_NUM_KERNELS > 1) ? $clog2(`ZN_NUM_KERNELS) : 1;

    localparam zy_net_pkg::word_t FC_W [`ZN_OUTPUT_SIZE][`ZN_NUM_KERNELS] = '{
        '{`ZN_FC_W_0_0, `ZN_FC_W_0_1},
        '{`ZN_FC_W_1_0, `ZN_FC_W_1_1},
        '{`ZN_FC_W_2_0, `ZN_FC_W_2_1},
        '{`ZN_FC_W_3_0, `ZN_FC_W_3_1}
    };

    localparam zy_net_pkg::word_t FC_B [`ZN_OUTPUT_SIZE] =
        '{`ZN_FC_B_0, `ZN_FC_B_1, `ZN_FC_B_2, `ZN_FC_B_3};

    zy_net_pkg::fc_state_t state_q;
    zy_net_pkg::acc_t      acc_q [`ZN_OUTPUT_SIZE];
    logic [IDX_W-1:0]      idx_q;
    logic                  clear;
    logic                  last;

    assign ren_o   = (state_q == zy_net_pkg::FC_READ) & ~empty_i;
    assign valid_o = (state_q == zy_net_pkg::FC_DONE);
    assign clear   = start_i | (valid_o & yumi_i);
    assign last    = (idx_q == IDX_W'(`ZN_NUM_KERNELS - 1));

    // scores are taken straight from the accumulators, stable while held
    always_comb begin
        for (int o = 0; o < `ZN_OUTPUT_SIZE; o++) begin
            data_o[o] = zy_net_pkg::sat_word(acc_q[o] >>> `ZN_FRAC_BITS);
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= zy_net_pkg::FC_READ;
            idx_q   <= '0;
            for (int o = 0; o < `ZN_OUTPUT_SIZE; o++) begin
                acc_q[o] <= zy_net_pkg::acc_t'(FC_B[o]) <<< `ZN_FRAC_BITS;
            end
        end else if (clear) begin
            state_q <= zy_net_pkg::FC_READ;
            idx_q   <= '0;
            // bias is pre-scaled so it lines up with the products
            for (int o = 0; o < `ZN_OUTPUT_SIZE; o++) begin
                acc_q[o] <= zy_net_pkg::acc_t'(FC_B[o]) <<< `ZN_FRAC_BITS;
            end
        end else if (ren_o) begin
            for (int o = 0; o < `ZN_OUTPUT_SIZE; o++) begin
                acc_q[o] <= acc_q[o] + zy_net_pkg::acc_t'(data_i) *
                            zy_net_pkg::acc_t'(FC_W[o][idx_q]);
            end
            if (last) begin
                idx_q   <= '0;
                state_q <= zy_net_pkg::FC_DONE;
            end else begin
                idx_q <= idx_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: zy_net.sv
`default_nettype none

`include "zy_net_consts.svh"

module zy_net (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   start_i,
    input  zy_net_pkg::word_t      data_i,
    input  logic                   valid_i,
    output logic                   ready_o,
    output zy_net_pkg::score_vec_t data_o,
    output logic                   valid_o,
    input  logic                   yumi_i
);

    logic [`ZN_NUM_KERNELS-1:0] conv_ready;
    logic [`ZN_NUM_KERNELS-1:0] conv_valid;
    logic [`ZN_NUM_KERNELS-1:0] conv_yumi;
    zy_net_pkg::word_t          conv_data [`ZN_NUM_KERNELS];

    logic [`ZN_NUM_KERNELS-1:0] gap_valid;
    logic                       gap_ready;
    zy_net_pkg::feat_vec_t      gap_data;

    logic                       ser_ready;
    logic                       ser_wen;
    zy_net_pkg::word_t          ser_data;

    logic                       fifo_full;
    logic                       fifo_empty;
    zy_net_pkg::word_t          fifo_data;

    logic                       fc_ren;

    // kernels take samples in lockstep
    assign ready_o = &conv_ready;

    // features leave together, only once every kernel has one
    assign gap_ready = ser_ready & (&gap_valid);

    for (genvar k = 0; k < `ZN_NUM_KERNELS; k++) begin : g_kernel
        conv_layer u_conv (
            .clk_i,
            .arst_n_i,
            .start_i,
            .kernel_sel_i   (1'(k)),
            .valid_i,
            .shared_ready_i (ready_o),
            .data_i,
            .ready_o        (conv_ready[k]),
            .valid_o        (conv_valid[k]),
            .yumi_i         (conv_yumi[k]),
            .data_o         (conv_data[k])
        );

        gap_layer u_gap (
            .clk_i,
            .arst_n_i,
            .start_i,
            .valid_i (conv_valid[k]),
            .ready_o (conv_yumi[k]),
            .data_i  (conv_data[k]),
            .valid_o (gap_valid[k]),
            .ready_i (gap_ready),
            .data_o  (gap_data[k])
        );
    end

    fc_output_layer u_serializer (
        .clk_i,
        .arst_n_i,
        .valid_i (&gap_valid),
        .ready_o (ser_ready),
        .data_i  (gap_data),
        .wen_o   (ser_wen),
        .full_i  (fifo_full),
        .data_o  (ser_data)
    );

    sample_fifo u_fifo (
        .clk_i,
        .arst_n_i,
        .wen_i   (ser_wen),
        .full_o  (fifo_full),
        .data_i  (ser_data),
        .ren_i   (fc_ren),
        .empty_o (fifo_empty),
        .data_o  (fifo_data)
    );

    fc_layer u_dense (
        .clk_i,
        .arst_n_i,
        .start_i,
        .data_i  (fifo_data),
        .empty_i (fifo_empty),
        .ren_o   (fc_ren),
        .valid_o,
        .yumi_i,
        .data_o
    );

endmodule

`default_nettype wire

// File: tb_zy_net.sv
`default_nettype none

`include "zy_net_consts.svh"

module tb_zy_net;

    localparam int CLK_PERIOD      = 100;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 200;
    localparam int SAMPLE_TIMEOUT  = 50;
    localparam int RESULT_TIMEOUT  = 100;

    // kernel taps and dense layer as given for the network
    localparam zy_net_pkg::word_t TAPS [`ZN_NUM_KERNELS][`ZN_KERNEL_HEIGHT] = '{
        '{`ZN_K0_W0, `ZN_K0_W1, `ZN_K0_W2, `ZN_K0_W3},
        '{`ZN_K1_W0, `ZN_K1_W1, `ZN_K1_W2, `ZN_K1_W3}
    };
    localparam zy_net_pkg::word_t DENSE_W [`ZN_OUTPUT_SIZE][`ZN_NUM_KERNELS] = '{
        '{`ZN_FC_W_0_0, `ZN_FC_W_0_1},
        '{`ZN_FC_W_1_0, `ZN_FC_W_1_1},
        '{`ZN_FC_W_2_0, `ZN_FC_W_2_1},
        '{`ZN_FC_W_3_0, `ZN_FC_W_3_1}
    };
    localparam zy_net_pkg::word_t DENSE_B [`ZN_OUTPUT_SIZE] =
        '{`ZN_FC_B_0, `ZN_FC_B_1, `ZN_FC_B_2, `ZN_FC_B_3};

    logic                   clk = 1'b0;
    logic                   arst_n;
    logic                   start;
    logic                   in_valid;
    logic                   in_ready;
    logic                   out_valid;
    logic                   out_yumi;
    zy_net_pkg::word_t      in_data;
    zy_net_pkg::score_vec_t out_data;

    zy_net_pkg::word_t      frame [`ZN_INPUT_LEN];
    zy_net_pkg::score_vec_t last_scores;
    int unsigned            lcg_state = 32'd94731;
    int                     errors = 0;
    int                     tests_run = 0;
    int                     tests_failed = 0;

    zy_net u_dut (
        .clk_i    (clk),
        .arst_n_i (arst_n),
        .start_i  (start),
        .data_i   (in_data),
        .valid_i  (in_valid),
        .ready_o  (in_ready),
        .data_o   (out_data),
        .valid_o  (out_valid),
        .yumi_i   (out_yumi)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // uniform sample in -2.0 .. +2.0
    function automatic zy_net_pkg::word_t rand_sample();
        int span;
        span = int'((next_rand() >> 8) % 32'd16385);
        return zy_net_pkg::word_t'(span - 8192);
    endfunction

    function automatic longint clamp_word(input longint v);
        if (v > 32767) begin
            return 32767;
        end
        if (v < -32768) begin
            return -32768;
        end
        return v;
    endfunction

    // output j covers samples j .. j+3, oldest sample on tap 0
    function automatic longint conv_ref(input int k, input int j);
        longint sum;
        sum = 0;
        for (int t = 0; t < `ZN_KERNEL_HEIGHT; t++) begin
            sum += longint'(TAPS[k][t]) * longint'(frame[j + t]);
        end
        return clamp_word(sum >>> `ZN_FRAC_BITS);
    endfunction

    function automatic zy_net_pkg::word_t feature_ref(input int k);
        longint sum;
        longint c;
        sum = 0;
        for (int j = 0; j < `ZN_CONV_LEN; j++) begin
            c = conv_ref(k, j);
            sum += clamp_word((c < 0) ? -c : c);
        end
        return zy_net_pkg::word_t'(clamp_word(sum >>> `ZN_CONV_LEN_LOG2));
    endfunction

    function automatic zy_net_pkg::score_vec_t scores_ref();
        zy_net_pkg::score_vec_t s;
        longint acc;
        for (int o = 0; o < `ZN_OUTPUT_SIZE; o++) begin
            acc = longint'(DENSE_B[o]) <<< `ZN_FRAC_BITS;
            for (int k = 0; k < `ZN_NUM_KERNELS; k++) begin
                acc += longint'(feature_ref(k)) * longint'(DENSE_W[o][k]);
            end
            s[o] = zy_net_pkg::word_t'(clamp_word(acc >>> `ZN_FRAC_BITS));
        end
        return s;
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input zy_net_pkg::word_t got,
                              input zy_net_pkg::word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%04h expected 0x%04h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_scores(input string name, input zy_net_pkg::score_vec_t got,
                                input zy_net_pkg::score_vec_t exp);
        for (int o = 0; o < `ZN_OUTPUT_SIZE; o++) begin
            if (got[o] !== exp[o]) begin
                $display("[FAIL] %s[%0d] got 0x%04h expected 0x%04h", name, o, got[o], exp[o]);
                errors++;
            end
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
        end
    endtask

    // start pulse, then the frame through the valid/ready handshake
    task automatic send_frame();
        int stall;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        for (int i = 0; i < `ZN_INPUT_LEN; i++) begin
            in_valid <= 1'b1;
            in_data  <= frame[i];
            stall = 0;
            @(negedge clk);
            while (!in_ready && stall < SAMPLE_TIMEOUT) begin
                @(negedge clk);
                stall++;
            end
            if (!in_ready) begin
                $display("sample %0d was never accepted, ready_o stayed low", i);
                errors++;
            end
            @(posedge clk);
        end
        in_valid <= 1'b0;
    endtask

    // hold yumi low for hold cycles before taking the scores
    task automatic run_frame(input string name, input int hold);
        zy_net_pkg::score_vec_t exp;
        int waited;
        send_frame();
        waited = 0;
        @(negedge clk);
        while (!out_valid && waited < RESULT_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!out_valid) begin
            $display("%s: no score vector within %0d cycles of the last sample",
                     name, RESULT_TIMEOUT);
            errors++;
            return;
        end
        exp = scores_ref();
        for (int k = 0; k < `ZN_NUM_KERNELS; k++) begin
            check_word($sformatf("%s feature %0d", name, k), u_dut.gap_data[k], feature_ref(k));
        end
        check_scores({name, " data_o"}, out_data, exp);
        last_scores = out_data;
        for (int c = 0; c < hold; c++) begin
            @(negedge clk);
            check_bit({name, " valid_o while held"}, out_valid, 1'b1);
            check_scores({name, " data_o while held"}, out_data, exp);
        end
        @(posedge clk);
        out_yumi <= 1'b1;
        @(posedge clk);
        out_yumi <= 1'b0;
        @(negedge clk);
        check_bit({name, " valid_o after yumi"}, out_valid, 1'b0);
    endtask

    task automatic check_reset_state();
        int e0;
        e0 = errors;
        @(negedge clk);
        check_bit("valid_o", out_valid, 1'b0);
        check_bit("ready_o", in_ready, 1'b1);
        report_test("reset state", e0);
    endtask

    task automatic constant_frame();
        int e0;
        e0 = errors;
        for (int i = 0; i < `ZN_INPUT_LEN; i++) begin
            frame[i] = 16'h1000;
        end
        run_frame("constant", 0);
        check_scores("constant literal", last_scores,
                     {16'h0F00, 16'h0900, 16'h0000, 16'h1000});
        report_test("constant frame", e0);
    endtask

    task automatic random_frame();
        int e0;
        e0 = errors;
        for (int i = 0; i < `ZN_INPUT_LEN; i++) begin
            frame[i] = rand_sample();
        end
        run_frame("random", 0);
        report_test("random frame", e0);
    endtask

    task automatic hold_backpressure();
        int e0;
        int hold;
        e0 = errors;
        hold = 3 + int'((next_rand() >> 16) % 32'd16);
        for (int i = 0; i < `ZN_INPUT_LEN; i++) begin
            frame[i] = rand_sample();
        end
        run_frame("held", hold);
        // the chain must take a new frame after the stall
        for (int i = 0; i < `ZN_INPUT_LEN; i++) begin
            frame[i] = zy_net_pkg::word_t'(i * 16'h0180 - 16'h0C00);
        end
        run_frame("after hold", 0);
        report_test("back-pressure", e0);
    endtask

    task automatic saturating_frames();
        int e0;
        e0 = errors;
        for (int i = 0; i < `ZN_INPUT_LEN; i++) begin
            frame[i] = 16'h7FFF;
        end
        run_frame("max", 0);
        check_scores("max literal", last_scores, {16'h7EFF, 16'h40FF, 16'h0000, 16'h7FFF});
        // full-scale alternation drives kernel 1 and score 3 into the rails
        for (int i = 0; i < `ZN_INPUT_LEN; i++) begin
            frame[i] = (i % 2 == 0) ? 16'h7FFF : 16'h8000;
        end
        run_frame("alternating", 0);
        check_scores("alternating literal", last_scores,
                     {16'h8000, 16'h4100, 16'h7FFF, 16'h0001});
        report_test("saturation", e0);
    endtask

    task automatic back_to_back_frames();
        int e0;
        e0 = errors;
        for (int i = 0; i < `ZN_INPUT_LEN; i++) begin
            frame[i] = rand_sample();
        end
        run_frame("first", 0);
        for (int i = 0; i < `ZN_INPUT_LEN; i++) begin
            frame[i] = zy_net_pkg::word_t'(16'h0900 - i * 16'h0100);
        end
        run_frame("second", 0);
        report_test("two frames", e0);
    endtask

    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("watchdog expired before the tests completed");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        arst_n   <= 1'b0;
        start    <= 1'b0;
        in_valid <= 1'b0;
        in_data  <= '0;
        out_yumi <= 1'b0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        check_reset_state();
        constant_frame();
        random_frame();
        hold_backpressure();
        saturating_frames();
        back_to_back_frames();

        $display("%0d tests run, %0d failing, %0d mismatches", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
zy_net_pkg.sv
conv_layer.sv
gap_layer.sv
fc_output_layer.sv
sample_fifo.sv
fc_layer.sv
zy_net.sv
tb_zy_net.sv

// File: Bender.yml
package:
  name: zy_net

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - zy_net_pkg.sv
      - conv_layer.sv
      - gap_layer.sv
      - fc_output_layer.sv
      - sample_fifo.sv
      - fc_layer.sv
      - zy_net.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_zy_net.sv
